//--- verification/audio_i2s_stim.txt
// columns: left right mute, hex, one line per frame
// mute 1 sends the frame as silence whatever the samples are
1234 abcd 0
8000 7fff 0
ffff 0000 0
0001 8000 0
a5a5 5a5a 1
c3c3 3c3c 0
0000 ffff 0
dead beef 1
face cafe 1
7fff 8001 0
0f0f f0f0 0
5555 aaaa 0
0000 0000 0
fffe 0001 0
4321 8765 1
9abc 1357 0

//--- flist.f
+incdir+src
src/audio_pkg.sv
src/sample_latch.sv
src/i2s_frame_timer.sv
src/i2s_serializer.sv
src/audio_i2s_top.sv
verification/audio_i2s_chk.sv
verification/audio_i2s_tb.sv

//--- Makefile
# verilator flow for the i2s transmitter testbench
VERILATOR ?= verilator
TOP       ?= audio_i2s_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

SRCS := $(filter-out +%,$(shell cat $(FLIST))) src/audio_consts.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/audio_i2s_tb.sv
/*
 * testbench for the serial audio transmitter
 * stimulus lines from a text file, i2s stream decode per slot
 * pin timing checks, watchdog and error summary
 */

`default_nettype none
`timescale 1ns/1ns

`include "audio_consts.svh"

module audio_i2s_tb
    import audio_pkg::*;
();

    localparam int    CLK_PERIOD   = 100;
    localparam int    MAX_LINES    = 64;
    localparam int    FRAME_CYCLES = 2 * `AUD_SLOTS_PER_CH * `AUD_MCLK_DIV;
    localparam string STIM_FILE    = "verification/audio_i2s_stim.txt";

    logic      audgen_mclk;
    logic      reset_n;
    logic      sample_valid;
    logic      mute;
    aud_pair_t sample_in;
    logic      sample_request;
    logic      audio_sclk;
    logic      audio_lrck;
    logic      audio_dac;

    // one entry per frame, file lines then the random pair
    aud_pair_t line_pair [MAX_LINES + 1];
    logic      line_mute [MAX_LINES + 1];
    aud_pair_t exp_pair  [MAX_LINES + 1];
    int        n_frames;
    bit        stim_loaded = 1'b0;
    integer    seed;
    int        mismatch_count = 0;
    int        other_errors = 0;
    int        frames_done = 0;

    ////////////////////////////////
    // pin monitor state
    ////////////////////////////////
    int   reset_cyc = 0;
    int   run_cyc = 0;
    int   last_sclk_rise = -1;
    int   last_lrck_edge = -1;
    int   last_req = -1;
    int   slot_idx = -1;
    logic cur_ch = 1'b0;
    logic prev_sclk = 1'b0;
    logic prev_lrck = 1'b0;
    logic [`AUD_SAMPLE_W-1:0] word = '0;

    audio_i2s_top audio_i2s_top_i (.*);

    initial begin
        audgen_mclk = 1'b0;
        forever #(CLK_PERIOD / 2) audgen_mclk = ~audgen_mclk;
    end

    task automatic compare_value(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH time %0t %s expected %0h actual %0h",
                     $time, sig, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic drive_line(input int k);
        sample_valid <= 1'b1;
        sample_in    <= line_pair[k];
        mute         <= line_mute[k];
    endtask

    // one sclk rise; slot count restarts on each lrck change
    task automatic decode_bit(input logic ch, input logic dac);
        if (ch != cur_ch) begin
            cur_ch   = ch;
            slot_idx = 0;
        end else begin
            slot_idx++;
        end
        assert (slot_idx < `AUD_SLOTS_PER_CH) else begin
            $display("framing error at %0t: too many slots in one channel", $time);
            other_errors++;
        end
        if (slot_idx >= 1 && slot_idx <= `AUD_SAMPLE_W) begin
            word = {word[`AUD_SAMPLE_W-2:0], dac};
        end else begin
            // slot 0 delay bit and tail padding
            compare_value("audio_dac pad bit", 32'd0, 32'(dac));
        end
        if (slot_idx == `AUD_SAMPLE_W && frames_done < n_frames) begin
            compare_value(ch ? "audio_dac right word" : "audio_dac left word",
                          32'(ch ? exp_pair[frames_done].right : exp_pair[frames_done].left),
                          32'(word));
        end
        if (ch && slot_idx == `AUD_SLOTS_PER_CH - 1) begin
            frames_done++;
        end
    endtask

    // pre-edge pin values, stable at every mclk rise
    always @(posedge audgen_mclk) begin
        if ((!reset_n && reset_cyc > 0) || (reset_n && run_cyc == 0)) begin
            assert ({audio_sclk, audio_lrck, audio_dac, sample_request} == 4'b0000) else begin
                $display("reset error at %0t: outputs not low before the first frame", $time);
                other_errors++;
            end
        end
        if (!reset_n) begin
            reset_cyc++;
        end else begin
            if (sample_request) begin
                if (last_req >= 0)
                    compare_value("sample_request period", FRAME_CYCLES, run_cyc - last_req);
                last_req = run_cyc;
            end
            if (audio_lrck != prev_lrck) begin
                if (last_lrck_edge >= 0)
                    compare_value("audio_lrck half period", FRAME_CYCLES / 2,
                                  run_cyc - last_lrck_edge);
                last_lrck_edge = run_cyc;
                // request and the lrck fall leave the same mclk edge
                if (!audio_lrck)
                    compare_value("sample_request at lrck fall", 32'd1, 32'(sample_request));
            end
            if (audio_sclk && !prev_sclk) begin
                if (last_sclk_rise >= 0)
                    compare_value("audio_sclk period", `AUD_MCLK_DIV, run_cyc - last_sclk_rise);
                last_sclk_rise = run_cyc;
                decode_bit(audio_lrck, audio_dac);
            end
            prev_sclk = audio_sclk;
            prev_lrck = audio_lrck;
            run_cyc++;
        end
    end

    initial begin
        integer      fd;
        string       text;
        logic [15:0] l_val;
        logic [15:0] r_val;
        logic [15:0] m_val;
        logic [31:0] rnd;
        int          n_lines;
        reset_n      = 1'b0;
        sample_valid = 1'b0;
        mute         = 1'b0;
        sample_in    = '0;
        seed         = 32'hf28c;
        n_lines      = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                text = "";
                void'($fgets(text, fd));
                if ($sscanf(text, "%h %h %h", l_val, r_val, m_val) == 3) begin
                    line_pair[n_lines] = '{left: l_val, right: r_val};
                    line_mute[n_lines] = m_val[0];
                    n_lines++;
                end
            end
            $fclose(fd);
        end
        if (n_lines == 0) begin
            $display("stimulus file %s missing or without sample lines", STIM_FILE);
            other_errors++;
        end
        // random pair sent unmuted as the last frame
        rnd = $random(seed);
        line_pair[n_lines].left = rnd[15:0];
        rnd = $random(seed);
        line_pair[n_lines].right = rnd[15:0];
        line_mute[n_lines] = 1'b0;
        n_frames = n_lines + 1;
        for (int i = 0; i < n_frames; i++) begin
            if (line_mute[i])
                exp_pair[i] = '{left: '0, right: '0};
            else
                exp_pair[i] = line_pair[i];
        end
        stim_loaded = 1'b1;

        // first pair goes into the pending register while reset is low
        repeat (7) @(posedge audgen_mclk);
        drive_line(0);
        @(posedge audgen_mclk);
        sample_valid <= 1'b0;
        reset_n      <= 1'b1;
        for (int k = 1; k < n_frames; k++) begin
            do @(posedge audgen_mclk); while (sample_request !== 1'b1);
            drive_line(k);
            @(posedge audgen_mclk);
            sample_valid <= 1'b0;
        end
        wait (frames_done == n_frames);
        $display("summary: %0d frames checked, %0d mismatches, %0d other errors",
                 frames_done, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // watchdog, all frames plus two spare frames
    initial begin
        wait (stim_loaded);
        #((n_frames + 2) * FRAME_CYCLES * CLK_PERIOD + 16 * CLK_PERIOD);
        $display("timeout: only %0d of %0d frames decoded", frames_done, n_frames);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/audio_i2s_chk.sv
/*
 * concurrent assertions on the i2s pin timing
 * sclk period, lrck change point, sample_request width
 */

`default_nettype none
`timescale 1ns/1ns

`include "audio_consts.svh"

module audio_i2s_chk
    import audio_pkg::*;
(
    input logic       audgen_mclk,
    input logic       reset_n,
    input slot_tick_t slot_tick,
    input logic       audio_sclk,
    input logic       audio_lrck,
    input logic       sample_request
);

    // cycles since reset release, saturating
    logic [2:0] run_cnt;

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            run_cnt <= '0;
        end else if (run_cnt != 3'd7) begin
            run_cnt <= run_cnt + 3'd1;
        end
    end

    ////////////////////////////////
    // pin timing
    ////////////////////////////////

    sclk_period_a: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        (run_cnt == 3'd7) |-> (audio_sclk == $past(audio_sclk, `AUD_MCLK_DIV)))
        else $error("audio_sclk does not repeat every %0d mclk cycles", `AUD_MCLK_DIV);

    sclk_high_a: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $rose(audio_sclk) |=> audio_sclk)
        else $error("audio_sclk high for a single mclk cycle");

    // lrck moves with the registered sclk fall
    lrck_edge_a: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_lrck) |-> ($past(slot_tick.slot_start) && $fell(audio_sclk)))
        else $error("audio_lrck changed away from an sclk fall");

    req_width_a: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $rose(sample_request) |=> !sample_request)
        else $error("sample_request wider than one mclk cycle");

endmodule

bind audio_i2s_top audio_i2s_chk audio_i2s_chk_i (
    .audgen_mclk    (audgen_mclk),
    .reset_n        (reset_n),
    .slot_tick      (slot_tick),
    .audio_sclk     (audio_sclk),
    .audio_lrck     (audio_lrck),
    .sample_request (sample_request)
);

`default_nettype wire

//--- src/audio_i2s_top.sv
/*
 * audio_i2s_top
 * serial audio transmitter, latch, frame timer and serializer
 */

`default_nettype none
`timescale 1ns/1ns

`include "audio_consts.svh"

module audio_i2s_top
    import audio_pkg::*;
(
    input  logic      audgen_mclk,
    input  logic      reset_n,
    input  logic      sample_valid,
    input  logic      mute,
    input  aud_pair_t sample_in,
    output logic      sample_request,
    output logic      audio_sclk,
    output logic      audio_lrck,
    output logic      audio_dac
);

    // frame position from the timer
    slot_tick_t slot_tick;
    // pair held for the current frame
    aud_pair_t  active_pair;

    ////////////////////////////////
    // input side
    ////////////////////////////////

    sample_latch sample_latch_i (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .sample_valid   (sample_valid),
        .sample_in      (sample_in),
        .mute           (mute),
        .slot_tick      (slot_tick),
        .active_pair    (active_pair),
        .sample_request (sample_request)
    );

    // sclk = mclk / 4, 64 slots per lrck frame
    i2s_frame_timer i2s_frame_timer_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .slot_tick   (slot_tick)
    );

    ////////////////////////////////
    // output side
    ////////////////////////////////

    i2s_serializer i2s_serializer_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .slot_tick   (slot_tick),
        .active_pair (active_pair),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

endmodule

`default_nettype wire

//--- src/i2s_serializer.sv
/*
 * i2s_serializer
 * per channel shift register, msb first in slots 1..16
 * registered sclk, lrck and dac pins
 */

`default_nettype none
`timescale 1ns/1ns

`include "audio_consts.svh"

module i2s_serializer
    import audio_pkg::*;
(
    input  logic       audgen_mclk,
    input  logic       reset_n,
    input  slot_tick_t slot_tick,
    input  aud_pair_t  active_pair,
    output logic       audio_sclk,
    output logic       audio_lrck,
    output logic       audio_dac
);

    localparam logic [`AUD_DIV_W-1:0]  SCLK_HIGH = `AUD_DIV_W'(`AUD_MCLK_DIV / 2);
    localparam logic [`AUD_SLOT_W-1:0] LAST_BIT  = `AUD_SLOT_W'(`AUD_SAMPLE_W);

    logic [`AUD_DIV_W-1:0]    phase_cnt;
    logic [`AUD_DIV_W-1:0]    phase;
    logic                     load_q;
    logic                     bit_slot;
    logic [`AUD_SAMPLE_W-1:0] shift_reg;

    // divider phase, realigned on every slot start
    assign phase = slot_tick.slot_start ? '0 : phase_cnt;

    // slots 1..16 carry data, slot 0 is the i2s delay bit
    assign bit_slot = (slot_tick.slot != '0) && (slot_tick.slot <= LAST_BIT);

    ////////////////////////////////
    // shift register
    ////////////////////////////////

    // load one cycle into slot 0, active pair has settled by then
    always_ff @(posedge audgen_mclk) begin
        if (load_q) begin
            shift_reg <= slot_tick.channel ? active_pair.right : active_pair.left;
        end else if (slot_tick.slot_start && bit_slot) begin
            shift_reg <= {shift_reg[`AUD_SAMPLE_W-2:0], 1'b0};
        end
    end

    ////////////////////////////////
    // pins
    ////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            phase_cnt  <= '0;
            load_q     <= 1'b0;
            audio_sclk <= 1'b0;
            audio_lrck <= 1'b0;
            audio_dac  <= 1'b0;
        end else begin
            phase_cnt <= phase + 1'b1;
            load_q    <= slot_tick.slot_start && (slot_tick.slot == '0);
            // high in counts 2 and 3, one cycle late like the other pins
            audio_sclk <= (phase >= SCLK_HIGH);
            if (slot_tick.slot_start) begin
                audio_lrck <= slot_tick.channel;
                // msb of the shifter, zero padding elsewhere
                audio_dac  <= bit_slot ? shift_reg[`AUD_SAMPLE_W-1] : 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/i2s_frame_timer.sv
/*
 * i2s_frame_timer
 * mclk divider, bit slot counter and channel bit
 * slot tick decode shared by latch and serializer
 */

`default_nettype none
`timescale 1ns/1ns

`include "audio_consts.svh"

module i2s_frame_timer
    import audio_pkg::*;
(
    input  logic       audgen_mclk,
    input  logic       reset_n,
    output slot_tick_t slot_tick
);

    localparam logic [`AUD_DIV_W-1:0]  DIV_LAST  = `AUD_DIV_W'(`AUD_MCLK_DIV - 1);
    localparam logic [`AUD_SLOT_W-1:0] SLOT_LAST = `AUD_SLOT_W'(`AUD_SLOTS_PER_CH - 1);

    logic [`AUD_DIV_W-1:0]  div_cnt;
    logic [`AUD_SLOT_W-1:0] slot_cnt;
    logic                   channel;

    ////////////////////////////////
    // counters
    ////////////////////////////////

    // div 0..3, slot 0..31, channel flips after slot 31
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt  <= '0;
            slot_cnt <= '0;
            channel  <= 1'b0;
        end else begin
            if (div_cnt == DIV_LAST) begin
                div_cnt <= '0;
                if (slot_cnt == SLOT_LAST) begin
                    slot_cnt <= '0;
                    channel  <= ~channel;
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////
    // tick decode
    ////////////////////////////////

    // count 0 is the sclk fall, first cycle out of reset is a frame start
    always_comb begin
        slot_tick.slot_start  = (div_cnt == '0);
        slot_tick.frame_start = slot_tick.slot_start && (slot_cnt == '0) && !channel;
        slot_tick.channel     = channel;
        slot_tick.slot        = slot_cnt;
    end

endmodule

`default_nettype wire

//--- src/sample_latch.sv
/*
 * sample_latch
 * pending pair register, frame start transfer with mute, sample request
 */

`default_nettype none
`timescale 1ns/1ns

`include "audio_consts.svh"

module sample_latch
    import audio_pkg::*;
(
    input  logic       audgen_mclk,
    input  logic       reset_n,
    input  logic       sample_valid,
    input  aud_pair_t  sample_in,
    input  logic       mute,
    input  slot_tick_t slot_tick,
    output aud_pair_t  active_pair,
    output logic       sample_request
);

    aud_pair_t pending_pair;

    // newest offer wins, older pairs are dropped
    always_ff @(posedge audgen_mclk) begin
        if (sample_valid) begin
            pending_pair <= sample_in;
        end
    end

    // take the pending pair once per frame
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            active_pair    <= '0;
            sample_request <= 1'b0;
        end else begin
            sample_request <= slot_tick.frame_start;
            if (slot_tick.frame_start) begin
                // muted frame goes out as silence
                active_pair <= mute ? aud_pair_t'('0) : pending_pair;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/audio_pkg.sv
/*
 * audio_pkg
 * stereo sample pair and frame slot timing types
 */

`default_nettype none

`include "audio_consts.svh"

package audio_pkg;

    // one stereo sample pair, left in the upper word
    typedef struct packed {
        logic [`AUD_SAMPLE_W-1:0] left;
        logic [`AUD_SAMPLE_W-1:0] right;
    } aud_pair_t;

    // frame position, decoded once in the timer
    typedef struct packed {
        // first mclk of a bit slot, i.e. sclk falling edge
        logic                   slot_start;
        // slot_start of left slot 0
        logic                   frame_start;
        // 0 left, 1 right
        logic                   channel;
        logic [`AUD_SLOT_W-1:0] slot;
    } slot_tick_t;

endpackage

`default_nettype wire

//--- src/audio_consts.svh
/*
 * constants for the serial audio transmitter
 * sample width, bit slots per channel, MCLK to SCLK divide
 */

`ifndef AUDIO_CONSTS_SVH
`define AUDIO_CONSTS_SVH

// bits per sample word, sent msb first
`define AUD_SAMPLE_W 16

// bit slots in one channel half of the frame
`define AUD_SLOTS_PER_CH 32

// slot index width within a channel
`define AUD_SLOT_W 5

// mclk cycles per sclk period
`define AUD_MCLK_DIV 4
`define AUD_DIV_W 2

`endif
